// File: src.f
+incdir+hw
+incdir+testbench
hw/cpu_pkg.sv
hw/regfile.sv
hw/alu.sv
hw/inst_decode.sv
hw/cpu.sv
hw/data_ram.sv
hw/cpu_top.sv
testbench/tb_cpu_top.sv

// File: Bender.yml
package:
  name: acc_cpu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/regfile.sv
      - hw/alu.sv
      - hw/inst_decode.sv
      - hw/cpu.sv
      - hw/data_ram.sv
      - hw/cpu_top.sv
  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_cpu_top.sv

// File: testbench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program image, first byte sits at the reset vector
localparam int prog_len = 92;
localparam logic [7:0] prog_bytes [prog_len] = '{
	// immediate alu chain, each result stored
	`CPU_OP_LD_XL_IMMD, 8'h5a,
	`CPU_OP_ADD_XL_IMMD, 8'hc3,
	`CPU_OP_LD_DIR_XL, 8'h00, 8'h01,
	`CPU_OP_SUB_XL_IMMD, 8'h2f,
	`CPU_OP_LD_DIR_XL, 8'h01, 8'h01,
	`CPU_OP_AND_XL_IMMD, 8'h3c,
	`CPU_OP_LD_DIR_XL, 8'h02, 8'h01,
	`CPU_OP_OR_XL_IMMD, 8'h81,
	`CPU_OP_LD_DIR_XL, 8'h03, 8'h01,
	`CPU_OP_XOR_XL_IMMD, 8'hff,
	`CPU_OP_LD_DIR_XL, 8'h04, 8'h01,
	// store then load back at once
	`CPU_OP_LD_DIR_XL, 8'h10, 8'h01,
	`CPU_OP_LD_XL_DIR, 8'h10, 8'h01,
	`CPU_OP_ADD_XL_DIR, 8'h00, 8'h01,
	`CPU_OP_LD_DIR_XL, 8'h11, 8'h01,
	// zero result, jrz skips the poison store
	`CPU_OP_SUB_XL_IMMD, 8'h6f,
	`CPU_OP_JRZ_D, 8'h05,
	`CPU_OP_LD_DIR_XL, 8'had, 8'h0b,
	`CPU_OP_LD_XL_IMMD, 8'hf0,          // 402e
	`CPU_OP_ADD_XL_IMMD, 8'h20,
	`CPU_OP_JRNC_D, 8'h05,
	`CPU_OP_LD_DIR_XL, 8'h20, 8'h01,
	// yl as accumulator, word add, push and pop
	`CPU_OP_LDW_Y_IMMD, 8'h34, 8'h12,
	`CPU_OP_ALTACC2,
	`CPU_OP_LD_XL_IMMD, 8'h77,
	`CPU_OP_ADDW_Y_X,
	`CPU_OP_ALTACC2,
	`CPU_OP_PUSH_XL,
	`CPU_OP_POP_XL,
	`CPU_OP_LD_DIR_XL, 8'h30, 8'h01,
	// absolute jumps
	`CPU_OP_JP_IMMD, 8'h4a, 8'h40,
	`CPU_OP_LD_DIR_XL, 8'had, 8'h0b,
	`CPU_OP_LD_XL_IMMD, 8'h3e,          // 404a
	`CPU_OP_LD_DIR_XL, 8'h40, 8'h01,
	`CPU_OP_LDW_Y_IMMD, 8'h56, 8'h40,
	`CPU_OP_JP_Y,
	`CPU_OP_LD_DIR_XL, 8'had, 8'h0b,
	`CPU_OP_ADD_XL_IMMD, 8'h01,         // 4056
	`CPU_OP_LD_DIR_XL, 8'h41, 8'h01,
	`CPU_OP_TRAP
};

// stores in program order as {address, data byte}
localparam int store_count = 12;
localparam logic [23:0] store_list [store_count] = '{
	{16'h0100, 8'h1d}, {16'h0101, 8'hee}, {16'h0102, 8'h2c}, {16'h0103, 8'had},
	{16'h0104, 8'h52}, {16'h0110, 8'h52}, {16'h0111, 8'h6f}, {16'h0120, 8'h10},
	{16'h0fff, 8'h87}, {16'h0130, 8'h87}, {16'h0140, 8'h3e}, {16'h0141, 8'h3f}
};

`endif

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu_top;

	`include "tb_program.svh"

	localparam logic [15:0] poison_addr = 16'h0bad;
	localparam int trap_timeout = 500;

	logic clk;
	logic reset;
	cpu_pkg::inst_t iread_data = '0;
	cpu_pkg::word_t iread_addr;
	cpu_pkg::mem_write_t dwrite;
	logic trap;
	logic [3:0] store_index;
	logic [23:0] expected_store;

	cpu_top DUT
	(
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.iread_addr(iread_addr),
		.dwrite(dwrite),
		.trap(trap)
	);

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		$display("Fail %s: got %h, expected %h", name, got, expected);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		stop_with_failure();
	endtask

	// bytes outside the program read as trap
	function automatic logic [7:0] rom_byte(input logic [15:0] addr);
		logic [15:0] offset;
		offset = addr - `CPU_RESET_PC;
		if (offset < prog_len)
			return prog_bytes[offset[6:0]];
		else
			return `CPU_OP_TRAP;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// registered instruction rom
	always @(posedge clk)
	begin
		iread_data <= {rom_byte(iread_addr + 16'd2), rom_byte(iread_addr + 16'd1),
			rom_byte(iread_addr)};
	end

	always @(posedge clk)
	begin
		if (reset)
			store_index <= '0;
		else if (dwrite.en != 2'b00)
			store_index <= store_index + 4'd1;
	end

	always_comb
	begin
		if (store_index < store_count)
			expected_store = store_list[store_index];
		else
			expected_store = '0;
	end

	// quiet core through reset and the first cycle after it
	assert property (@(posedge clk) reset || $fell(reset) |-> dwrite.en == 2'b00)
		else report_mismatch("dwrite.en", $sampled(dwrite.en), 16'h0000);
	assert property (@(posedge clk) reset || $fell(reset) |-> !trap)
		else report_mismatch("trap", $sampled(trap), 16'h0000);
	assert property (@(posedge clk) reset |-> iread_addr == `CPU_RESET_PC)
		else report_mismatch("iread_addr", $sampled(iread_addr), `CPU_RESET_PC);

	assert property (@(posedge clk) disable iff (reset)
		dwrite.en != 2'b00 |-> store_index < store_count)
		else report_problem("a store was made after the expected store list ran out");
	assert property (@(posedge clk) disable iff (reset)
		dwrite.en != 2'b00 |-> dwrite.addr != poison_addr)
		else report_problem("a store reached the poison address");
	assert property (@(posedge clk) disable iff (reset)
		dwrite.en != 2'b00 |-> dwrite.addr == expected_store[23:8])
		else report_mismatch("dwrite.addr", $sampled(dwrite.addr),
			$sampled(expected_store[23:8]));
	assert property (@(posedge clk) disable iff (reset)
		dwrite.en != 2'b00 |-> dwrite.data[7:0] == expected_store[7:0])
		else report_mismatch("dwrite.data", $sampled(dwrite.data[7:0]),
			$sampled(expected_store[7:0]));
	assert property (@(posedge clk) disable iff (reset)
		dwrite.en != 2'b00 |-> dwrite.en == 2'b01)
		else report_mismatch("dwrite.en", $sampled(dwrite.en), 16'h0001);
	// every store done by the time trap shows up
	assert property (@(posedge clk) disable iff (reset) trap |-> store_index == store_count)
		else report_mismatch("store_index", $sampled(store_index), store_count);

	initial
	begin
		int cycles;
		logic trap_seen;
		reset = 1'b1;
		trap_seen = 1'b0;
		cycles = 0;
		repeat (3)
			@(posedge clk);
		reset <= 1'b0;
		while (!trap_seen && cycles < trap_timeout)
		begin
			@(negedge clk);
			cycles++;
			if (trap)
				trap_seen = 1'b1;
		end
		// next rising edge runs the assertions on trap
		@(negedge clk);
		if (trap_seen)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
			report_problem("trap never reached");
	end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top
(
	input wire clk,
	input wire reset,
	input wire cpu_pkg::inst_t iread_data,
	output cpu_pkg::word_t iread_addr,
	output cpu_pkg::mem_write_t dwrite,
	output logic trap
);
	cpu_pkg::word_t dread_addr;
	cpu_pkg::word_t dread_data;

	// instruction memory sits outside, data memory is local
	cpu u_cpu
	(
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.dread_data(dread_data),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.dwrite(dwrite),
		.trap(trap)
	);

	data_ram u_ram
	(
		.clk(clk),
		.dread_addr(dread_addr),
		.dwrite(dwrite),
		.dread_data(dread_data)
	);

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram
(
	input wire clk,
	input wire cpu_pkg::word_t dread_addr,
	input wire cpu_pkg::mem_write_t dwrite,
	output cpu_pkg::word_t dread_data
);
	cpu_pkg::byte_t mem [65536];
	cpu_pkg::word_t rd_addr_hi;
	cpu_pkg::word_t wr_addr_hi;
	cpu_pkg::byte_t rd_lo;
	cpu_pkg::byte_t rd_hi;

	assign rd_addr_hi = dread_addr + 16'd1;
	assign wr_addr_hi = dwrite.addr + 16'd1;

	// write first, a byte stored this cycle wins over the array
	always_comb
	begin
		rd_lo = mem[dread_addr];
		rd_hi = mem[rd_addr_hi];
		if (dwrite.en[0] && dwrite.addr == dread_addr)
			rd_lo = dwrite.data[7:0];
		if (dwrite.en[1] && wr_addr_hi == dread_addr)
			rd_lo = dwrite.data[15:8];
		if (dwrite.en[0] && dwrite.addr == rd_addr_hi)
			rd_hi = dwrite.data[7:0];
		if (dwrite.en[1] && wr_addr_hi == rd_addr_hi)
			rd_hi = dwrite.data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (dwrite.en[0])
			mem[dwrite.addr] <= dwrite.data[7:0];
		if (dwrite.en[1])
			mem[wr_addr_hi] <= dwrite.data[15:8];
		dread_data <= {rd_hi, rd_lo};
	end

endmodule

`default_nettype wire

// File: hw/cpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module cpu
(
	input wire clk,
	input wire reset,
	input wire cpu_pkg::inst_t iread_data,
	input wire cpu_pkg::word_t dread_data,
	output cpu_pkg::word_t iread_addr,
	output cpu_pkg::word_t dread_addr,
	output cpu_pkg::mem_write_t dwrite,
	output logic trap
);
	cpu_pkg::inst_t inst;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::opcode_t next_opcode;
	cpu_pkg::ctrl_t ctrl;
	cpu_pkg::flags_t flags;
	cpu_pkg::flags_t next_flags;
	cpu_pkg::word_t pc, next_pc, sp, next_sp;
	cpu_pkg::word_t x, y, z, next_x, next_y, next_z;
	cpu_pkg::word_t op0, op1, result;
	cpu_pkg::word_t wacc, next_wacc;
	cpu_pkg::byte_t acc;
	cpu_pkg::reg_write_t reg_wr;
	logic c_out, n_out, z_out;
	logic [1:0] inst_len;
	logic jr_taken;

	regfile u_regfile (.clk, .reset, .wr(reg_wr), .x, .y, .z, .next_x, .next_y, .next_z);
	alu u_alu (.aluop(ctrl.aluop), .op0, .op1, .c_in(flags.c), .result, .c_out, .n_out, .z_out);
	inst_decode u_decode (.opcode, .ctrl);

	assign opcode = inst[7:0];
	assign next_opcode = iread_data[7:0];

	always_comb
	begin
		case (next_opcode)
			`CPU_OP_LD_XL_IMMD, `CPU_OP_ADD_XL_IMMD, `CPU_OP_SUB_XL_IMMD,
			`CPU_OP_AND_XL_IMMD, `CPU_OP_OR_XL_IMMD, `CPU_OP_XOR_XL_IMMD,
			`CPU_OP_JR_D, `CPU_OP_JRZ_D, `CPU_OP_JRNZ_D, `CPU_OP_JRC_D, `CPU_OP_JRNC_D:
				inst_len = 2'd2;
			`CPU_OP_LDW_Y_IMMD, `CPU_OP_LD_XL_DIR, `CPU_OP_LD_DIR_XL, `CPU_OP_JP_IMMD,
			`CPU_OP_ADD_XL_DIR, `CPU_OP_SUB_XL_DIR, `CPU_OP_AND_XL_DIR,
			`CPU_OP_OR_XL_DIR, `CPU_OP_XOR_XL_DIR:
				inst_len = 2'd3;
			default:
				inst_len = 2'd1;
		endcase
	end

	// conditions see the flags the executing instruction is producing
	assign jr_taken = next_opcode == `CPU_OP_JR_D ||
		next_opcode == `CPU_OP_JRZ_D && next_flags.z ||
		next_opcode == `CPU_OP_JRNZ_D && !next_flags.z ||
		next_opcode == `CPU_OP_JRC_D && next_flags.c ||
		next_opcode == `CPU_OP_JRNC_D && !next_flags.c;

	assign wacc = (flags.acc_sel == 2'd2) ? x : (flags.acc_sel == 2'd3) ? z : y;
	assign next_wacc = (next_flags.acc_sel == 2'd2) ? next_x :
		(next_flags.acc_sel == 2'd3) ? next_z : next_y;

	always_comb
	begin
		if (reset)
			next_pc = `CPU_RESET_PC;
		else if (next_opcode == `CPU_OP_JP_IMMD)
			next_pc = iread_data[23:8];
		else if (next_opcode == `CPU_OP_JP_Y)
			next_pc = next_wacc;
		else if (jr_taken)
			// offset relative to the jr opcode itself
			next_pc = pc + {{8{iread_data[15]}}, iread_data[15:8]};
		else
			next_pc = pc + 16'(inst_len);
	end

	assign iread_addr = next_pc;
	// only pop and the direct forms use the read data
	assign dread_addr = (next_opcode == `CPU_OP_POP_XL) ? next_sp : iread_data[23:8];

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
		begin
			inst <= {16'h0000, `CPU_OP_NOP};
			sp <= `CPU_RESET_SP;
			flags <= '0;
		end
		else
		begin
			inst <= iread_data;
			sp <= next_sp;
			flags <= next_flags;
		end
	end

	assign acc = (flags.acc_sel == 2'd1) ? x[15:8] :
		(flags.acc_sel == 2'd2) ? y[7:0] :
		(flags.acc_sel == 2'd3) ? z[7:0] : x[7:0];

	always_comb
	begin
		case (ctrl.src0)
			`CPU_SRC0_ACC:
				op0 = {8'h00, acc};
			`CPU_SRC0_MEM:
				op0 = dread_data;
			`CPU_SRC0_IMM:
				op0 = inst[23:8];
			default:
				op0 = wacc;
		endcase
		case (ctrl.src1)
			`CPU_SRC1_MEM:
				op1 = dread_data;
			`CPU_SRC1_X:
				op1 = x;
			default:
				op1 = {8'h00, inst[15:8]};
		endcase
	end

	// altacc holds for one instruction only
	always_comb
	begin
		next_flags = flags;
		next_flags.acc_sel = ctrl.is_altacc;
		if (ctrl.set_c)
			next_flags.c = c_out;
		if (ctrl.set_nz)
		begin
			next_flags.n = n_out;
			next_flags.z = z_out;
		end
	end

	assign next_sp = ctrl.sp_inc ? sp + 16'd1 : ctrl.sp_dec ? sp - 16'd1 : sp;

	always_comb
	begin
		reg_wr.addr = 2'd0;
		reg_wr.en = 2'b00;
		reg_wr.data = {result[7:0], result[7:0]};
		if (ctrl.reg_lane)
		begin
			reg_wr.addr = (flags.acc_sel == 2'd2) ? 2'd1 : (flags.acc_sel == 2'd3) ? 2'd2 : 2'd0;
			reg_wr.en = (flags.acc_sel == 2'd1) ? 2'b10 : 2'b01;
		end
		else if (ctrl.reg_word)
		begin
			reg_wr.addr = (flags.acc_sel == 2'd2) ? 2'd0 : (flags.acc_sel == 2'd3) ? 2'd2 : 2'd1;
			reg_wr.en = 2'b11;
			reg_wr.data = result;
		end
	end

	assign dwrite.addr = (ctrl.mem_addr == `CPU_MADDR_PUSH) ? sp - 16'd1 : inst[23:8];
	assign dwrite.data = result;
	assign dwrite.en = ctrl.mem_write ? 2'b01 : 2'b00;
	assign trap = ctrl.is_trap;

	// a reset edge leaves nop in the instruction register
	assert property (@(posedge clk) reset |=> dwrite.en == 2'b00);
	assert property (@(posedge clk) reset |=> !trap);

endmodule

`default_nettype wire

// File: hw/inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module inst_decode
(
	input wire cpu_pkg::opcode_t opcode,
	output cpu_pkg::ctrl_t ctrl
);

	always_comb
	begin
		ctrl = '0;
		ctrl.aluop = `CPU_ALU_PASS;
		ctrl.src0 = `CPU_SRC0_ACC;
		ctrl.src1 = `CPU_SRC1_IMM;
		ctrl.mem_addr = `CPU_MADDR_DIR;
		case (opcode)
			`CPU_OP_LD_XL_IMMD:
			begin
				ctrl.src0 = `CPU_SRC0_IMM;
				ctrl.reg_lane = 1'b1;
			end
			`CPU_OP_LDW_Y_IMMD:
			begin
				ctrl.aluop = `CPU_ALU_PASSW;
				ctrl.src0 = `CPU_SRC0_IMM;
				ctrl.reg_word = 1'b1;
			end
			`CPU_OP_ADD_XL_IMMD, `CPU_OP_ADD_XL_DIR,
			`CPU_OP_SUB_XL_IMMD, `CPU_OP_SUB_XL_DIR:
			begin
				ctrl.aluop = opcode[0] ? `CPU_ALU_SUB : `CPU_ALU_ADD;
				ctrl.reg_lane = 1'b1;
				ctrl.set_c = 1'b1;
				ctrl.set_nz = 1'b1;
			end
			`CPU_OP_AND_XL_IMMD, `CPU_OP_AND_XL_DIR,
			`CPU_OP_OR_XL_IMMD, `CPU_OP_OR_XL_DIR,
			`CPU_OP_XOR_XL_IMMD, `CPU_OP_XOR_XL_DIR:
			begin
				// logic ops keep carry
				ctrl.aluop = {1'b0, opcode[2:0]};
				ctrl.reg_lane = 1'b1;
				ctrl.set_nz = 1'b1;
			end
			`CPU_OP_ADDW_Y_X:
			begin
				ctrl.aluop = `CPU_ALU_ADDW;
				ctrl.src0 = `CPU_SRC0_WACC;
				ctrl.src1 = `CPU_SRC1_X;
				ctrl.reg_word = 1'b1;
				ctrl.set_c = 1'b1;
				ctrl.set_nz = 1'b1;
			end
			`CPU_OP_LD_XL_DIR:
			begin
				ctrl.src0 = `CPU_SRC0_MEM;
				ctrl.reg_lane = 1'b1;
			end
			`CPU_OP_LD_DIR_XL:
				ctrl.mem_write = 1'b1;
			`CPU_OP_PUSH_XL:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.mem_addr = `CPU_MADDR_PUSH;
				ctrl.sp_dec = 1'b1;
			end
			`CPU_OP_POP_XL:
			begin
				ctrl.src0 = `CPU_SRC0_MEM;
				ctrl.reg_lane = 1'b1;
				ctrl.sp_inc = 1'b1;
			end
			`CPU_OP_ALTACC1, `CPU_OP_ALTACC2, `CPU_OP_ALTACC3:
				ctrl.is_altacc = opcode[1:0] + 2'd1;
			`CPU_OP_TRAP:
				ctrl.is_trap = 1'b1;
			default:
				// jumps finish in fetch, unknown opcodes act as nop
				ctrl.aluop = `CPU_ALU_PASS;
		endcase

		// direct forms take the second operand from memory
		if (opcode >= `CPU_OP_ADD_XL_DIR && opcode <= `CPU_OP_XOR_XL_DIR)
			ctrl.src1 = `CPU_SRC1_MEM;
	end

	always_comb
		assert final (!(ctrl.sp_inc && ctrl.sp_dec));

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module alu
(
	input wire cpu_pkg::aluop_t aluop,
	input wire cpu_pkg::word_t op0,
	input wire cpu_pkg::word_t op1,
	input wire c_in,
	output cpu_pkg::word_t result,
	output logic c_out,
	output logic n_out,
	output logic z_out
);
	logic wide;

	always_comb
	begin
		result = '0;
		c_out = c_in;
		wide = 1'b0;
		case (aluop)
			`CPU_ALU_ADD:
				{c_out, result[7:0]} = {1'b0, op0[7:0]} + {1'b0, op1[7:0]};
			`CPU_ALU_SUB:
				// bit 8 of the difference is the borrow
				{c_out, result[7:0]} = {1'b0, op0[7:0]} - {1'b0, op1[7:0]};
			`CPU_ALU_AND:
				result[7:0] = op0[7:0] & op1[7:0];
			`CPU_ALU_OR:
				result[7:0] = op0[7:0] | op1[7:0];
			`CPU_ALU_XOR:
				result[7:0] = op0[7:0] ^ op1[7:0];
			`CPU_ALU_ADDW:
			begin
				{c_out, result} = {1'b0, op0} + {1'b0, op1};
				wide = 1'b1;
			end
			`CPU_ALU_PASSW:
			begin
				result = op0;
				wide = 1'b1;
			end
			default:
				// plain pass of the low byte
				result[7:0] = op0[7:0];
		endcase
	end

	assign n_out = wide ? result[15] : result[7];
	assign z_out = wide ? (result == 16'h0000) : (result[7:0] == 8'h00);

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile
(
	input wire clk,
	input wire reset,
	input wire cpu_pkg::reg_write_t wr,
	output cpu_pkg::word_t x,
	output cpu_pkg::word_t y,
	output cpu_pkg::word_t z,
	output cpu_pkg::word_t next_x,
	output cpu_pkg::word_t next_y,
	output cpu_pkg::word_t next_z
);
	cpu_pkg::word_t regs [3];
	cpu_pkg::word_t next_regs [3];

	// merge this cycle's write lane by lane
	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			next_regs[i] = regs[i];
			if (wr.addr == 2'(i) && wr.en[0])
				next_regs[i][7:0] = wr.data[7:0];
			if (wr.addr == 2'(i) && wr.en[1])
				next_regs[i][15:8] = wr.data[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (reset)
				regs[i] <= '0;
			else
				regs[i] <= next_regs[i];
		end
	end

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];
	assign next_x = next_regs[0];
	assign next_y = next_regs[1];
	assign next_z = next_regs[2];

	// accumulator mapping in the cpu only ever selects x, y or z
	assert property (@(posedge clk) disable iff (reset) wr.en != 2'b00 |-> wr.addr != 2'd3);

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	// opcode in bits 7:0, operands little endian above it
	typedef logic [23:0] inst_t;
	typedef logic [7:0] opcode_t;
	typedef logic [3:0] aluop_t;
	// bit 1 is the high byte
	typedef logic [1:0] lanes_t;
	typedef logic [1:0] src_sel_t;

	typedef struct packed {
		logic [1:0] acc_sel;
		logic c;
		logic n;
		logic z;
	} flags_t;

	typedef struct packed {
		aluop_t aluop;
		src_sel_t src0;
		src_sel_t src1;
		logic reg_lane;
		logic reg_word;
		logic mem_write;
		logic mem_addr;
		logic sp_inc;
		logic sp_dec;
		logic set_c;
		logic set_nz;
		logic [1:0] is_altacc;
		logic is_trap;
	} ctrl_t;

	typedef struct packed {
		logic [1:0] addr;
		lanes_t en;
		word_t data;
	} reg_write_t;

	typedef struct packed {
		word_t addr;
		word_t data;
		lanes_t en;
	} mem_write_t;

endpackage

`default_nettype wire

// File: hw/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_RESET_PC 16'h4000
`define CPU_RESET_SP 16'h1000

// opcodes, low byte of the instruction word
`define CPU_OP_NOP          8'h00
`define CPU_OP_TRAP         8'h01
`define CPU_OP_LD_XL_IMMD   8'h10
`define CPU_OP_LDW_Y_IMMD   8'h11
`define CPU_OP_LD_XL_DIR    8'h12
`define CPU_OP_LD_DIR_XL    8'h13
`define CPU_OP_PUSH_XL      8'h14
`define CPU_OP_POP_XL       8'h15
`define CPU_OP_ADDW_Y_X     8'h16
`define CPU_OP_ADD_XL_IMMD  8'h20
`define CPU_OP_SUB_XL_IMMD  8'h21
`define CPU_OP_AND_XL_IMMD  8'h22
`define CPU_OP_OR_XL_IMMD   8'h23
`define CPU_OP_XOR_XL_IMMD  8'h24
`define CPU_OP_ADD_XL_DIR   8'h28
`define CPU_OP_SUB_XL_DIR   8'h29
`define CPU_OP_AND_XL_DIR   8'h2a
`define CPU_OP_OR_XL_DIR    8'h2b
`define CPU_OP_XOR_XL_DIR   8'h2c
`define CPU_OP_JP_IMMD      8'h30
`define CPU_OP_JP_Y         8'h31
`define CPU_OP_JR_D         8'h38
`define CPU_OP_JRZ_D        8'h39
`define CPU_OP_JRNZ_D       8'h3a
`define CPU_OP_JRC_D        8'h3b
`define CPU_OP_JRNC_D       8'h3c
`define CPU_OP_ALTACC1      8'h40
`define CPU_OP_ALTACC2      8'h41
`define CPU_OP_ALTACC3      8'h42

// alu operations, 8-bit unless marked w
`define CPU_ALU_ADD   4'h0
`define CPU_ALU_SUB   4'h1
`define CPU_ALU_AND   4'h2
`define CPU_ALU_OR    4'h3
`define CPU_ALU_XOR   4'h4
`define CPU_ALU_PASS  4'h5
`define CPU_ALU_ADDW  4'h6
`define CPU_ALU_PASSW 4'h7

// operand and store address selectors
`define CPU_SRC0_ACC   2'd0
`define CPU_SRC0_MEM   2'd1
`define CPU_SRC0_IMM   2'd2
`define CPU_SRC0_WACC  2'd3
`define CPU_SRC1_IMM   2'd0
`define CPU_SRC1_MEM   2'd1
`define CPU_SRC1_X     2'd2
`define CPU_MADDR_DIR  1'b0
`define CPU_MADDR_PUSH 1'b1

`endif
